// ==== decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::fd_t     fd_q,
    input  pipe_pkg::mw_t     mw_q,
    fwd_if.dec_side           fwd,
    output isa_pkg::ctrl_t    ctrl_d,
    output isa_pkg::reg_idx_t rs,
    output isa_pkg::reg_idx_t rt,
    output pipe_pkg::de_t     de_d,
    output isa_pkg::word_t    next_pc,
    input  isa_pkg::word_t    pc,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_reg,
    output isa_pkg::word_t    wb_data,
    output isa_pkg::word_t    wb_pc
);

    isa_pkg::word_t regs [1:31];
    isa_pkg::word_t rf_rs;
    isa_pkg::word_t rf_rt;
    isa_pkg::word_t rs_val;
    isa_pkg::word_t rt_val;
    isa_pkg::word_t imm_ext;
    isa_pkg::word_t target;
    logic [15:0] imm16;
    logic taken;

    decoder u_decoder (
        .instr (fd_q.instr),
        .ctrl  (ctrl_d),
        .rs    (rs),
        .rt    (rt),
        .imm16 (imm16)
    );

    // Writeback
    assign wb_reg = mw_q.ctrl.dst;
    assign wb_valid = (mw_q.ctrl.dst != '0);
    assign wb_data = mw_q.ctrl.mem_read ? mw_q.load_data : mw_q.alu_res;
    assign wb_pc = mw_q.pc;
    assign fwd.w_dst = mw_q.ctrl.dst;
    assign fwd.w_data = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rf_rs = (rs == '0) ? '0 : regs[rs];
    assign rf_rt = (rt == '0) ? '0 : regs[rt];

    // Memory stage first, then writeback, then the register file
    assign rs_val = (rs != '0 && rs == fwd.m_dst) ? fwd.m_data :
                    (rs != '0 && rs == fwd.w_dst) ? fwd.w_data : rf_rs;
    assign rt_val = (rt != '0 && rt == fwd.m_dst) ? fwd.m_data :
                    (rt != '0 && rt == fwd.w_dst) ? fwd.w_data : rf_rt;

    assign imm_ext = ctrl_d.ext_signed ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

    // Branch target is relative to the delay slot
    assign taken = ctrl_d.is_branch && (rs_val == rt_val);
    assign target = fd_q.pc + 32'd4 + {imm_ext[29:0], 2'b00};
    assign next_pc = taken ? target : pc + 32'd4;

    assign de_d.ctrl = ctrl_d;
    assign de_d.pc = fd_q.pc;
    assign de_d.rs = rs;
    assign de_d.rt = rt;
    assign de_d.rs_val = rs_val;
    assign de_d.rt_val = rt_val;
    assign de_d.imm = imm_ext;

endmodule

// ==== decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input  isa_pkg::word_t    instr,
    output isa_pkg::ctrl_t    ctrl,
    output isa_pkg::reg_idx_t rs,
    output isa_pkg::reg_idx_t rt,
    output logic [15:0]       imm16
);

    isa_pkg::instr_r_t f_r;
    isa_pkg::instr_i_t f_i;
    logic use_rs;
    logic use_rt;

    assign f_r = instr;
    assign f_i = instr;
    assign imm16 = f_i.imm;

    // Unused source fields read as register 0
    assign rs = use_rs ? f_r.rs : '0;
    assign rt = use_rt ? f_r.rt : '0;

    always_comb begin
        ctrl = '0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (f_r.opcode)
            isa_pkg::OP_SPECIAL: begin
                if (f_r.funct == isa_pkg::FN_ADDU || f_r.funct == isa_pkg::FN_SUBU) begin
                    ctrl.alu_op = (f_r.funct == isa_pkg::FN_SUBU) ? isa_pkg::ALU_SUB
                                                                  : isa_pkg::ALU_ADD;
                    ctrl.dst = f_r.rd;
                    ctrl.t_use_rs = 2'd1;
                    ctrl.t_use_rt = 2'd1;
                    ctrl.t_new = 2'd1;
                    use_rs = 1'b1;
                    use_rt = 1'b1;
                end
            end
            isa_pkg::OP_ORI: begin
                ctrl.alu_op = isa_pkg::ALU_OR;
                ctrl.opb_sel = isa_pkg::OPB_IMM;
                ctrl.dst = f_r.rt;
                ctrl.t_use_rs = 2'd1;
                ctrl.t_new = 2'd1;
                use_rs = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                ctrl.alu_op = isa_pkg::ALU_LUI;
                ctrl.opb_sel = isa_pkg::OPB_IMM;
                ctrl.dst = f_r.rt;
                ctrl.t_new = 2'd1;
            end
            isa_pkg::OP_LW: begin
                ctrl.opb_sel = isa_pkg::OPB_IMM;
                ctrl.ext_signed = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.dst = f_r.rt;
                ctrl.t_use_rs = 2'd1;
                ctrl.t_new = 2'd2;
                use_rs = 1'b1;
            end
            isa_pkg::OP_SW: begin
                ctrl.opb_sel = isa_pkg::OPB_IMM;
                ctrl.ext_signed = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.t_use_rs = 2'd1;
                ctrl.t_use_rt = 2'd2;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            isa_pkg::OP_BEQ: begin
                ctrl.ext_signed = 1'b1;
                ctrl.is_branch = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  pipe_pkg::de_t de_q,
    fwd_if.exe_side       fwd,
    output pipe_pkg::em_t em_d
);

    isa_pkg::word_t a;
    isa_pkg::word_t b_reg;
    isa_pkg::word_t b;
    isa_pkg::word_t result;

    // Operands may have been produced after decode read them
    assign a = (de_q.rs != '0 && de_q.rs == fwd.m_dst) ? fwd.m_data :
               (de_q.rs != '0 && de_q.rs == fwd.w_dst) ? fwd.w_data : de_q.rs_val;
    assign b_reg = (de_q.rt != '0 && de_q.rt == fwd.m_dst) ? fwd.m_data :
                   (de_q.rt != '0 && de_q.rt == fwd.w_dst) ? fwd.w_data : de_q.rt_val;

    assign b = (de_q.ctrl.opb_sel == isa_pkg::OPB_IMM) ? de_q.imm : b_reg;

    always_comb begin
        case (de_q.ctrl.alu_op)
            isa_pkg::ALU_SUB: result = a - b;
            isa_pkg::ALU_OR:  result = a | b;
            isa_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
            default:          result = a + b;
        endcase
    end

    assign em_d.ctrl = de_q.ctrl;
    assign em_d.pc = de_q.pc;
    assign em_d.rt = de_q.rt;
    assign em_d.alu_res = result;
    assign em_d.store_data = b_reg;

endmodule

// ==== filelist.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fwd_if.sv
pipe_reg.sv
decoder.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

// ==== fwd_if.sv ====
`timescale 1ns/100ps

interface fwd_if;
    // Memory stage result
    // m_dst is zero when it cannot forward
    isa_pkg::reg_idx_t m_dst;
    isa_pkg::word_t    m_data;
    // Writeback stage result
    isa_pkg::reg_idx_t w_dst;
    isa_pkg::word_t    w_data;

    modport mem_side (output m_dst, m_data, input w_dst, w_data);
    modport dec_side (output w_dst, w_data, input m_dst, m_data);
    modport exe_side (input m_dst, m_data, w_dst, w_data);
endinterface

// ==== hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  isa_pkg::reg_idx_t rs,
    input  isa_pkg::reg_idx_t rt,
    input  isa_pkg::ctrl_t    ctrl_d,
    input  pipe_pkg::de_t     de_q,
    input  pipe_pkg::em_t     em_q,
    output logic              stall
);

    isa_pkg::stage_time_t e_new;
    isa_pkg::stage_time_t m_new;
    logic rs_e;
    logic rs_m;
    logic rt_e;
    logic rt_m;

    assign e_new = de_q.ctrl.t_new;

    // One stage closer to its result than when it sat in execute
    assign m_new = (em_q.ctrl.t_new == 2'd0) ? 2'd0 : em_q.ctrl.t_new - 2'd1;

    assign rs_e = (rs != '0) && (rs == de_q.ctrl.dst) && (e_new > ctrl_d.t_use_rs);
    assign rt_e = (rt != '0) && (rt == de_q.ctrl.dst) && (e_new > ctrl_d.t_use_rt);
    assign rs_m = (rs != '0) && (rs == em_q.ctrl.dst) && (m_new > ctrl_d.t_use_rs);
    assign rt_m = (rt != '0) && (rt == em_q.ctrl.dst) && (m_new > ctrl_d.t_use_rt);

    assign stall = rs_e || rt_e || rs_m || rt_m;

endmodule

// ==== isa_pkg.sv ====
`include "mips_settings.svh"

package isa_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;
    typedef logic [1:0] stage_time_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI} alu_op_t;
    typedef enum logic {OPB_REG, OPB_IMM} opb_sel_t;

    // dst is zero when nothing is written back
    typedef struct packed {
        alu_op_t     alu_op;
        opb_sel_t    opb_sel;
        logic        ext_signed;
        logic        mem_write;
        logic        mem_read;
        logic        is_branch;
        reg_idx_t    dst;
        stage_time_t t_use_rs;
        stage_time_t t_use_rt;
        stage_time_t t_new;
    } ctrl_t;

endpackage

// ==== memory_stage.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module memory_stage (
    input  logic                 clk,
    input  pipe_pkg::em_t        em_q,
    fwd_if.mem_side              fwd,
    output pipe_pkg::mw_t        mw_d,
    output logic                 dm_we,
    output logic [`MIPS_XLEN-1:0] dm_addr,
    output logic [`MIPS_XLEN-1:0] dm_wdata
);

    localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

    isa_pkg::word_t mem [`MIPS_DMEM_WORDS] = '{default: '0};
    logic [IDX_W-1:0] idx;
    isa_pkg::word_t store_data;

    // Word index above the byte offset
    assign idx = em_q.alu_res[IDX_W+1:2];

    // A value written back this cycle is newer than the latched one
    assign store_data = (em_q.rt != '0 && em_q.rt == fwd.w_dst) ? fwd.w_data
                                                                : em_q.store_data;

    always_ff @(posedge clk) begin
        if (em_q.ctrl.mem_write) begin
            mem[idx] <= store_data;
        end
    end

    assign dm_we = em_q.ctrl.mem_write;
    assign dm_addr = em_q.alu_res;
    assign dm_wdata = store_data;

    // Load data is not ready until writeback
    assign fwd.m_dst = em_q.ctrl.mem_read ? '0 : em_q.ctrl.dst;
    assign fwd.m_data = em_q.alu_res;

    assign mw_d.ctrl = em_q.ctrl;
    assign mw_d.pc = em_q.pc;
    assign mw_d.alu_res = em_q.alu_res;
    assign mw_d.load_data = mem[idx];

endmodule

// ==== mips_core.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic [`MIPS_XLEN-1:0]   imem_addr,
    input  logic [`MIPS_XLEN-1:0]   imem_data,
    output logic                   wb_valid,
    output logic [`MIPS_REG_AW-1:0] wb_reg,
    output logic [`MIPS_XLEN-1:0]   wb_data,
    output logic [`MIPS_XLEN-1:0]   wb_pc,
    output logic                   dm_we,
    output logic [`MIPS_XLEN-1:0]   dm_addr,
    output logic [`MIPS_XLEN-1:0]   dm_wdata
);

    isa_pkg::word_t pc;
    isa_pkg::word_t next_pc;
    isa_pkg::ctrl_t ctrl_d;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    logic stall;

    pipe_pkg::fd_t fd_d;
    pipe_pkg::fd_t fd_q;
    pipe_pkg::de_t de_d;
    pipe_pkg::de_t de_q;
    pipe_pkg::em_t em_d;
    pipe_pkg::em_t em_q;
    pipe_pkg::mw_t mw_d;
    pipe_pkg::mw_t mw_q;

    fwd_if fwd ();

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    // Fetch is a combinational read by the instruction source
    assign imem_addr = pc;
    assign fd_d.instr = imem_data;
    assign fd_d.pc = pc;

    pipe_reg #(.payload_t(pipe_pkg::fd_t)) u_fd (
        .clk (clk), .reset (reset), .hold (stall), .bubble (1'b0), .d (fd_d), .q (fd_q)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .fd_q     (fd_q),
        .mw_q     (mw_q),
        .fwd      (fwd.dec_side),
        .ctrl_d   (ctrl_d),
        .rs       (rs),
        .rt       (rt),
        .de_d     (de_d),
        .next_pc  (next_pc),
        .pc       (pc),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .wb_pc    (wb_pc)
    );

    hazard_unit u_hazard (
        .rs (rs), .rt (rt), .ctrl_d (ctrl_d), .de_q (de_q), .em_q (em_q), .stall (stall)
    );

    // A stalled decode sends a bubble into execute
    pipe_reg #(.payload_t(pipe_pkg::de_t)) u_de (
        .clk (clk), .reset (reset), .hold (1'b0), .bubble (stall), .d (de_d), .q (de_q)
    );

    execute_stage u_execute (.de_q (de_q), .fwd (fwd.exe_side), .em_d (em_d));

    pipe_reg #(.payload_t(pipe_pkg::em_t)) u_em (
        .clk (clk), .reset (reset), .hold (1'b0), .bubble (1'b0), .d (em_d), .q (em_q)
    );

    memory_stage u_memory (
        .clk      (clk),
        .em_q     (em_q),
        .fwd      (fwd.mem_side),
        .mw_d     (mw_d),
        .dm_we    (dm_we),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata)
    );

    pipe_reg #(.payload_t(pipe_pkg::mw_t)) u_mw (
        .clk (clk), .reset (reset), .hold (1'b0), .bubble (1'b0), .d (mw_d), .q (mw_q)
    );

endmodule

// ==== mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Register index width
`define MIPS_REG_AW 5

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Data memory depth in words
`define MIPS_DMEM_WORDS 256

`endif

// ==== pipe_pkg.sv ====
package pipe_pkg;

    typedef struct packed {
        isa_pkg::word_t instr;
        isa_pkg::word_t pc;
    } fd_t;

    typedef struct packed {
        isa_pkg::ctrl_t    ctrl;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::word_t    rs_val;
        isa_pkg::word_t    rt_val;
        isa_pkg::word_t    imm;
    } de_t;

    typedef struct packed {
        isa_pkg::ctrl_t    ctrl;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rt;
        isa_pkg::word_t    alu_res;
        isa_pkg::word_t    store_data;
    } em_t;

    typedef struct packed {
        isa_pkg::ctrl_t ctrl;
        isa_pkg::word_t pc;
        isa_pkg::word_t alu_res;
        isa_pkg::word_t load_data;
    } mw_t;

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_mips_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== tb_mips_core.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module tb_mips_core;

    localparam int PROG_LEN = 200;
    localparam int RESET_CYCLES = 2;
    localparam int WATCHDOG_NS = PROG_LEN * 3 * 8 + 1000;

    // MIPS encodings
    // addi stands in for an unsupported opcode
    localparam logic [5:0] OPC_BEQ = 6'h04;
    localparam logic [5:0] OPC_ADDI = 6'h08;
    localparam logic [5:0] OPC_ORI = 6'h0d;
    localparam logic [5:0] OPC_LUI = 6'h0f;
    localparam logic [5:0] OPC_LW = 6'h23;
    localparam logic [5:0] OPC_SW = 6'h2b;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;

    logic clk;
    logic reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic wb_valid;
    logic [4:0] wb_reg;
    logic [31:0] wb_data;
    logic [31:0] wb_pc;
    logic dm_we;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;

    logic [31:0] program_mem [PROG_LEN];
    logic [31:0] lcg_state;

    // Expected register writes and stores in program order
    logic [4:0] exp_wb_reg [$];
    logic [31:0] exp_wb_data [$];
    logic [31:0] exp_wb_pc [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    int wb_errors;
    int st_errors;
    int other_errors;

    mips_core u_mips_core (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .wb_pc     (wb_pc),
        .dm_we     (dm_we),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() >> 16) % n;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Outside the program the instruction source returns zero
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        int idx;
        offset = addr - `MIPS_RESET_PC;
        idx = int'(offset >> 2);
        if (addr < `MIPS_RESET_PC || offset >= 32'(4 * PROG_LEN) || addr[1:0] != 2'b00) begin
            return 32'h0;
        end
        return program_mem[idx];
    endfunction

    task automatic build_program();
        int kind;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = rand_below(16);
            rs = 5'(rand_below(8));
            rt = 5'(rand_below(8));
            rd = 5'(rand_below(8));
            imm = 16'(next_rand() >> 16);
            case (kind)
                0, 1, 2: program_mem[i] = r_type(rs, rt, rd, FUNCT_ADDU);
                3, 4: program_mem[i] = r_type(rs, rt, rd, FUNCT_SUBU);
                5, 6: program_mem[i] = i_type(OPC_ORI, rs, rt, imm);
                7: program_mem[i] = i_type(OPC_LUI, 5'd0, rt, imm);
                8, 9, 10: program_mem[i] = i_type(OPC_LW, 5'd0, rt,
                                                  {6'd0, 8'(rand_below(64)), 2'b00});
                11, 12: program_mem[i] = i_type(OPC_SW, 5'd0, rt,
                                                {6'd0, 8'(rand_below(64)), 2'b00});
                13, 14: begin
                    // Equal operands half the time so that branches get taken
                    if (rand_below(2) == 0) begin
                        rt = rs;
                    end
                    program_mem[i] = i_type(OPC_BEQ, rs, rt, 16'(1 + rand_below(4)));
                end
                default: program_mem[i] = (rand_below(2) == 0) ? 32'h0
                                          : i_type(OPC_ADDI, rs, rt, imm);
            endcase
        end
    endtask

    // In-order ISA interpreter with one delay slot
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] dmem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0] dst;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h0;
        end
        pc = `MIPS_RESET_PC;
        npc = pc + 32'd4;
        while (pc >= `MIPS_RESET_PC && pc < `MIPS_RESET_PC + 32'(4 * PROG_LEN)) begin
            instr = fetch_word(pc);
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            sext = {{16{instr[15]}}, instr[15:0]};
            addr = a + sext;
            nnpc = npc + 32'd4;
            dst = 5'd0;
            val = 32'h0;
            case (instr[31:26])
                6'h00: begin
                    if (instr[5:0] == FUNCT_ADDU) begin
                        dst = instr[15:11];
                        val = a + b;
                    end else if (instr[5:0] == FUNCT_SUBU) begin
                        dst = instr[15:11];
                        val = a - b;
                    end
                end
                OPC_ORI: begin
                    dst = instr[20:16];
                    val = a | {16'h0000, instr[15:0]};
                end
                OPC_LUI: begin
                    dst = instr[20:16];
                    val = {instr[15:0], 16'h0000};
                end
                OPC_LW: begin
                    dst = instr[20:16];
                    val = dmem[addr[9:2]];
                end
                OPC_SW: begin
                    dmem[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                OPC_BEQ: begin
                    if (a == b) begin
                        nnpc = pc + 32'd4 + (sext << 2);
                    end
                end
                default: dst = 5'd0;
            endcase
            if (dst != 5'd0) begin
                regs[dst] = val;
                exp_wb_reg.push_back(dst);
                exp_wb_data.push_back(val);
                exp_wb_pc.push_back(pc);
            end
            pc = npc;
            npc = nnpc;
        end
    endtask

    task automatic check_writeback();
        logic [4:0] e_reg;
        logic [31:0] e_data;
        logic [31:0] e_pc;
        assert (wb_reg != 5'd0) else begin
            wb_errors++;
            $display("[FAIL] %0t: write to register 0 shown on wb_valid, pc %h", $time, wb_pc);
        end
        if (exp_wb_reg.size() == 0) begin
            other_errors++;
            $display("Register write at pc %h came after all expected writes", wb_pc);
        end else begin
            e_reg = exp_wb_reg.pop_front();
            e_data = exp_wb_data.pop_front();
            e_pc = exp_wb_pc.pop_front();
            assert (wb_reg == e_reg && wb_data == e_data && wb_pc == e_pc) else begin
                wb_errors++;
                $display("[FAIL] %0t: writeback r%0d=%h pc %h, expected r%0d=%h pc %h",
                         $time, wb_reg, wb_data, wb_pc, e_reg, e_data, e_pc);
            end
        end
    endtask

    task automatic check_store();
        logic [31:0] e_addr;
        logic [31:0] e_data;
        if (exp_st_addr.size() == 0) begin
            other_errors++;
            $display("Store to %h came after all expected stores", dm_addr);
        end else begin
            e_addr = exp_st_addr.pop_front();
            e_data = exp_st_data.pop_front();
            assert (dm_addr == e_addr && dm_wdata == e_data) else begin
                st_errors++;
                $display("[FAIL] %0t: store [%h]=%h, expected [%h]=%h",
                         $time, dm_addr, dm_wdata, e_addr, e_data);
            end
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: writeback %0d, store %0d, other %0d",
                 wb_errors, st_errors, other_errors);
        if (wb_errors + st_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (reset) begin
            assert (!wb_valid && !dm_we) else begin
                other_errors++;
                $display("Write strobe active during reset at %0t", $time);
            end
            assert (imem_addr == `MIPS_RESET_PC) else begin
                other_errors++;
                $display("[FAIL] %0t: imem_addr %h during reset, expected %h",
                         $time, imem_addr, `MIPS_RESET_PC);
            end
        end else begin
            if (wb_valid) begin
                check_writeback();
            end
            if (dm_we) begin
                check_store();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        imem_data <= fetch_word(imem_addr);
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        imem_data = 32'h0;
        lcg_state = 32'h709c_8b8c;
        wb_errors = 0;
        st_errors = 0;
        other_errors = 0;
        build_program();
        run_model();
        $display("Expecting %0d register writes and %0d stores",
                 exp_wb_reg.size(), exp_st_addr.size());
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        while (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
            @(posedge clk);
        end
        // Trailing nops would expose any extra writes
        repeat (10) @(posedge clk);
        report_and_finish();
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("Watchdog expired with %0d register writes and %0d stores still pending",
                 exp_wb_reg.size(), exp_st_addr.size());
        report_and_finish();
    end

endmodule
